/* source/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	localparam int XLEN = 32;
	localparam int RegAddrW = 5;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluSrl, aluLui
	} aluOpE;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSrcE;
	typedef enum logic [1:0] {fwdRegFile, fwdFromMem, fwdFromWb} fwdSelE;
	typedef enum logic [1:0] {npcSeq, npcBranch, npcJump} npcSelE;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [XLEN-1:0] adr;
		logic [XLEN-1:0] datW;
		logic [3:0] sel;
	} wbMasterT;

	typedef struct packed {
		logic ack;
		logic [XLEN-1:0] datR;
	} wbSlaveT;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rsVal;
		logic [XLEN-1:0] rtVal;
		logic [RegAddrW-1:0] rsIdx;
		logic [RegAddrW-1:0] rtIdx;
		logic [RegAddrW-1:0] dest;
		logic [XLEN-1:0] imm;
		logic [4:0] shamt;
		aluOpE aluOp;
		logic useImm;
		logic regWr;
		logic memRd;
		logic memWr;
		wbSrcE wbSrc;
	} idExT;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] aluOut;
		logic [XLEN-1:0] storeData;
		logic [RegAddrW-1:0] dest;
		logic regWr;
		logic memRd;
		logic memWr;
		wbSrcE wbSrc;
	} exMemT;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [RegAddrW-1:0] dest;
		logic regWr;
		logic [XLEN-1:0] data;
	} wbT;

	// operand select shared by the EX and branch forward paths
	function automatic logic [XLEN-1:0] fwdMux(fwdSelE sel, logic [XLEN-1:0] regVal,
			logic [XLEN-1:0] memVal, logic [XLEN-1:0] wbVal);
		case (sel)
			fwdFromMem: return memVal;
			fwdFromWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

endpackage

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [mipsPkg::RegAddrW-1:0] rsAddr,
	input wire logic [mipsPkg::RegAddrW-1:0] rtAddr,
	input wire mipsPkg::wbT wbStage,
	output logic [mipsPkg::XLEN-1:0] rsData,
	output logic [mipsPkg::XLEN-1:0] rtData
);
	import mipsPkg::*;

	// r0 has no storage
	logic [XLEN-1:0] regs [1:31];

	function automatic logic [XLEN-1:0] readPort(logic [RegAddrW-1:0] addr);
		if (addr == '0)
			return '0;
		if (wbStage.regWr && wbStage.dest == addr)
			return wbStage.data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wbStage.regWr && wbStage.dest != '0) begin
			regs[wbStage.dest] <= wbStage.data;
		end
	end

	assign rsData = readPort(rsAddr);
	assign rtData = readPort(rtAddr);

	// decode drops writes aimed at r0 before they reach this port
	assert property (@(posedge clk) disable iff (!rstN)
		wbStage.regWr |-> wbStage.dest != '0);

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
	input wire logic [mipsPkg::RegAddrW-1:0] rsAddr,
	input wire logic [mipsPkg::RegAddrW-1:0] rtAddr,
	input wire logic isBranch,
	input wire mipsPkg::idExT exStage,
	input wire mipsPkg::exMemT memStage,
	input wire mipsPkg::wbT wbStage,
	input wire logic fetchBusy,
	input wire logic dataBusy,
	output logic stall,
	output logic freeze,
	output mipsPkg::fwdSelE fwdA,
	output mipsPkg::fwdSelE fwdB,
	output mipsPkg::fwdSelE fwdBrA,
	output mipsPkg::fwdSelE fwdBrB
);
	import mipsPkg::*;

	logic loadUse, exHit, memLoadHit;

	// MEM wins over WB, r0 is never forwarded
	function automatic fwdSelE pickFwd(logic [RegAddrW-1:0] src);
		if (src != '0 && memStage.regWr && !memStage.memRd && memStage.dest == src)
			return fwdFromMem;
		if (src != '0 && wbStage.regWr && wbStage.dest == src)
			return fwdFromWb;
		return fwdRegFile;
	endfunction

	assign fwdA = pickFwd(exStage.rsIdx);
	assign fwdB = pickFwd(exStage.rtIdx);
	assign fwdBrA = pickFwd(rsAddr);
	assign fwdBrB = pickFwd(rtAddr);

	// regWr is already clear for r0 destinations
	assign exHit = exStage.regWr && (exStage.dest == rsAddr || exStage.dest == rtAddr);
	assign memLoadHit = memStage.regWr && memStage.memRd
		&& (memStage.dest == rsAddr || memStage.dest == rtAddr);
	assign loadUse = exHit && exStage.memRd;

	assign stall = loadUse || (isBranch && (exHit || memLoadHit));
	assign freeze = fetchBusy || dataBusy;

endmodule

`default_nettype wire

/* source/fetchUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchUnit #(
	parameter logic [mipsPkg::XLEN-1:0] ResetPc = 32'hbfc0_0000
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic stall,
	input wire logic freeze,
	input wire mipsPkg::npcSelE npcSel,
	input wire logic [mipsPkg::XLEN-1:0] branchTarget,
	input wire mipsPkg::wbSlaveT instrResp,
	output mipsPkg::wbMasterT instrBus,
	output logic fetchBusy,
	output logic [mipsPkg::XLEN-1:0] idPc,
	output logic [mipsPkg::XLEN-1:0] idInstr
);
	import mipsPkg::*;

	logic [XLEN-1:0] pc, nextPc, bufInstr, availInstr;
	logic busActive, bufValid, avail, advance;

	// an acked word waits in the buffer while the pipeline is held
	assign avail = bufValid || (busActive && instrResp.ack);
	assign availInstr = bufValid ? bufInstr : instrResp.datR;
	assign fetchBusy = !avail;
	assign advance = avail && !stall && !freeze;
	assign nextPc = (npcSel == npcSeq) ? pc + 32'd4 : branchTarget;

	always_comb begin
		instrBus.cyc = busActive;
		instrBus.stb = busActive;
		instrBus.we = 1'b0;
		instrBus.adr = pc;
		instrBus.datW = '0;
		instrBus.sel = 4'hf;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= ResetPc;
			busActive <= 1'b0;
			bufValid <= 1'b0;
			idPc <= '0;
			idInstr <= '0;
		end else if (advance) begin
			pc <= nextPc;
			busActive <= 1'b1;
			bufValid <= 1'b0;
			idPc <= pc;
			idInstr <= availInstr;
		end else if (busActive && instrResp.ack) begin
			busActive <= 1'b0;
			bufValid <= 1'b1;
		end else if (!bufValid) begin
			busActive <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (busActive && instrResp.ack)
			bufInstr <= instrResp.datR;
	end

	assert property (@(posedge clk) disable iff (!rstN) instrBus.stb |-> instrBus.cyc);
	// request stays up with a stable address until acked
	assert property (@(posedge clk) disable iff (!rstN)
		instrBus.stb && !instrResp.ack |=> instrBus.stb && $stable(instrBus.adr));

endmodule

`default_nettype wire

/* source/decodeCtrl.sv */
`timescale 1ns/100ps
`default_nettype none

module decodeCtrl (
	input wire logic clk,
	input wire logic rstN,
	input wire logic stall,
	input wire logic freeze,
	input wire logic [mipsPkg::XLEN-1:0] idPc,
	input wire logic [mipsPkg::XLEN-1:0] idInstr,
	input wire logic [mipsPkg::XLEN-1:0] rsData,
	input wire logic [mipsPkg::XLEN-1:0] rtData,
	input wire mipsPkg::fwdSelE fwdBrA,
	input wire mipsPkg::fwdSelE fwdBrB,
	input wire logic [mipsPkg::XLEN-1:0] memFwd,
	input wire logic [mipsPkg::XLEN-1:0] wbFwd,
	output logic [mipsPkg::RegAddrW-1:0] rsAddr,
	output logic [mipsPkg::RegAddrW-1:0] rtAddr,
	output logic isBranch,
	output mipsPkg::npcSelE npcSel,
	output logic [mipsPkg::XLEN-1:0] branchTarget,
	output mipsPkg::idExT exStage
);
	import mipsPkg::*;

	logic [5:0] opcode, funct;
	logic [RegAddrW-1:0] dest;
	logic [XLEN-1:0] imm32, brA, brB, seqPc;
	logic zeroExt, isJump, brNe, taken, regWr;
	idExT nextEx;

	assign opcode = idInstr[31:26];
	assign funct = idInstr[5:0];
	assign rsAddr = idInstr[25:21];
	assign rtAddr = idInstr[20:16];

	always_comb begin
		nextEx = '0;
		dest = idInstr[15:11];
		zeroExt = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		brNe = 1'b0;
		regWr = 1'b0;
		case (opcode)
			6'h00: begin
				regWr = 1'b1;
				case (funct)
					6'h21: nextEx.aluOp = aluAdd;
					6'h23: nextEx.aluOp = aluSub;
					6'h24: nextEx.aluOp = aluAnd;
					6'h25: nextEx.aluOp = aluOr;
					6'h26: nextEx.aluOp = aluXor;
					6'h2a: nextEx.aluOp = aluSlt;
					6'h00: nextEx.aluOp = aluSll;
					6'h02: nextEx.aluOp = aluSrl;
					default: regWr = 1'b0;
				endcase
			end
			6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0f: begin
				regWr = 1'b1;
				nextEx.useImm = 1'b1;
				dest = rtAddr;
				zeroExt = (opcode == 6'h0c) || (opcode == 6'h0d);
				case (opcode)
					6'h0a: nextEx.aluOp = aluSlt;
					6'h0c: nextEx.aluOp = aluAnd;
					6'h0d: nextEx.aluOp = aluOr;
					6'h0f: nextEx.aluOp = aluLui;
					default: nextEx.aluOp = aluAdd;
				endcase
			end
			6'h23: begin
				regWr = 1'b1;
				nextEx.useImm = 1'b1;
				nextEx.memRd = 1'b1;
				nextEx.wbSrc = wbMem;
				dest = rtAddr;
			end
			6'h2b: begin
				nextEx.useImm = 1'b1;
				nextEx.memWr = 1'b1;
			end
			6'h04: isBranch = 1'b1;
			6'h05: begin
				isBranch = 1'b1;
				brNe = 1'b1;
			end
			6'h02: isJump = 1'b1;
			6'h03: begin
				isJump = 1'b1;
				regWr = 1'b1;
				nextEx.wbSrc = wbLink;
				dest = 5'd31;
			end
			default: regWr = 1'b0;
		endcase
		imm32 = zeroExt ? {16'b0, idInstr[15:0]} : {{16{idInstr[15]}}, idInstr[15:0]};
		nextEx.pc = idPc;
		nextEx.rsVal = rsData;
		nextEx.rtVal = rtData;
		nextEx.rsIdx = rsAddr;
		nextEx.rtIdx = rtAddr;
		nextEx.dest = dest;
		nextEx.imm = imm32;
		nextEx.shamt = idInstr[10:6];
		// writes to r0 are dropped here, so nops never retire
		nextEx.regWr = regWr && (dest != '0);
	end

	// branch compare on forwarded operands
	assign brA = fwdMux(fwdBrA, rsData, memFwd, wbFwd);
	assign brB = fwdMux(fwdBrB, rtData, memFwd, wbFwd);
	assign taken = isBranch && ((brA == brB) != brNe);
	assign seqPc = idPc + 32'd4;
	assign npcSel = isJump ? npcJump : (taken ? npcBranch : npcSeq);
	assign branchTarget = isJump ? {seqPc[31:28], idInstr[25:0], 2'b00}
		: seqPc + {imm32[29:0], 2'b00};

	always_ff @(posedge clk) begin
		if (!rstN)
			exStage <= '0;
		else if (!freeze)
			exStage <= stall ? '0 : nextEx;
	end

endmodule

`default_nettype wire

/* source/execAlu.sv */
`timescale 1ns/100ps
`default_nettype none

module execAlu (
	input wire logic clk,
	input wire logic rstN,
	input wire logic freeze,
	input wire mipsPkg::idExT exStage,
	input wire mipsPkg::fwdSelE fwdA,
	input wire mipsPkg::fwdSelE fwdB,
	input wire logic [mipsPkg::XLEN-1:0] memFwd,
	input wire logic [mipsPkg::XLEN-1:0] wbFwd,
	output mipsPkg::exMemT memStage
);
	import mipsPkg::*;

	logic [XLEN-1:0] opA, rtFwd, opB, aluOut;

	assign opA = fwdMux(fwdA, exStage.rsVal, memFwd, wbFwd);
	assign rtFwd = fwdMux(fwdB, exStage.rtVal, memFwd, wbFwd);
	assign opB = exStage.useImm ? exStage.imm : rtFwd;

	always_comb begin
		case (exStage.aluOp)
			aluSub: aluOut = opA - opB;
			aluAnd: aluOut = opA & opB;
			aluOr: aluOut = opA | opB;
			aluXor: aluOut = opA ^ opB;
			aluSlt: aluOut = {31'b0, $signed(opA) < $signed(opB)};
			aluSll: aluOut = opB << exStage.shamt;
			aluSrl: aluOut = opB >> exStage.shamt;
			aluLui: aluOut = {opB[15:0], 16'b0};
			default: aluOut = opA + opB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memStage <= '0;
		end else if (!freeze) begin
			memStage.pc <= exStage.pc;
			memStage.aluOut <= aluOut;
			// sw takes the forwarded rt value
			memStage.storeData <= rtFwd;
			memStage.dest <= exStage.dest;
			memStage.regWr <= exStage.regWr;
			memStage.memRd <= exStage.memRd;
			memStage.memWr <= exStage.memWr;
			memStage.wbSrc <= exStage.wbSrc;
		end
	end

endmodule

`default_nettype wire

/* source/memAccess.sv */
`timescale 1ns/100ps
`default_nettype none

module memAccess (
	input wire logic clk,
	input wire logic rstN,
	input wire logic freeze,
	input wire mipsPkg::exMemT memStage,
	input wire mipsPkg::wbSlaveT dataResp,
	output mipsPkg::wbMasterT dataBus,
	output logic dataBusy,
	output logic [mipsPkg::XLEN-1:0] memFwd,
	output mipsPkg::wbT wbStage
);
	import mipsPkg::*;

	logic dataDone, req;
	logic [XLEN-1:0] loadHold, loadData, linkAddr;
	wbT wbNext;

	// done flag keeps a finished access from reissuing while frozen
	assign req = memStage.memRd || memStage.memWr;
	assign dataBusy = dataBus.stb && !dataResp.ack;
	assign loadData = dataDone ? loadHold : dataResp.datR;
	assign linkAddr = memStage.pc + 32'd8;
	assign memFwd = (memStage.wbSrc == wbLink) ? linkAddr : memStage.aluOut;

	always_comb begin
		dataBus.stb = req && !dataDone;
		dataBus.cyc = dataBus.stb;
		dataBus.we = memStage.memWr;
		dataBus.adr = memStage.aluOut;
		dataBus.datW = memStage.storeData;
		dataBus.sel = 4'hf;
		wbNext.pc = memStage.pc;
		wbNext.dest = memStage.dest;
		wbNext.regWr = memStage.regWr;
		wbNext.data = (memStage.wbSrc == wbMem) ? loadData : memFwd;
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			dataDone <= 1'b0;
		else if (!freeze)
			dataDone <= 1'b0;
		else if (dataBus.stb && dataResp.ack)
			dataDone <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (dataBus.stb && dataResp.ack)
			loadHold <= dataResp.datR;
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			wbStage <= '0;
		else if (!freeze)
			wbStage <= wbNext;
	end

	assert property (@(posedge clk) disable iff (!rstN) dataBus.stb |-> dataBus.cyc);
	assert property (@(posedge clk) disable iff (!rstN)
		dataBus.stb |-> dataBus.adr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* source/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
	parameter logic [mipsPkg::XLEN-1:0] ResetPc = 32'hbfc0_0000
) (
	input wire logic clk,
	input wire logic rstN,
	input wire mipsPkg::wbSlaveT instrResp,
	input wire mipsPkg::wbSlaveT dataResp,
	output mipsPkg::wbMasterT instrBus,
	output mipsPkg::wbMasterT dataBus,
	output logic [mipsPkg::XLEN-1:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [mipsPkg::RegAddrW-1:0] debugWbRfWnum,
	output logic [mipsPkg::XLEN-1:0] debugWbRfWdata
);
	import mipsPkg::*;

	logic stall, freeze, fetchBusy, dataBusy, isBranch, wbFresh;
	logic [XLEN-1:0] idPc, idInstr, branchTarget, rsData, rtData, memFwd;
	logic [RegAddrW-1:0] rsAddr, rtAddr;
	npcSelE npcSel;
	fwdSelE fwdA, fwdB, fwdBrA, fwdBrB;
	idExT exStage;
	exMemT memStage;
	wbT wbStage;

	fetchUnit #(.ResetPc(ResetPc)) u_fetchUnit (
		.clk(clk), .rstN(rstN), .stall(stall), .freeze(freeze), .npcSel(npcSel),
		.branchTarget(branchTarget), .instrResp(instrResp), .instrBus(instrBus),
		.fetchBusy(fetchBusy), .idPc(idPc), .idInstr(idInstr)
	);

	decodeCtrl u_decodeCtrl (
		.clk(clk), .rstN(rstN), .stall(stall), .freeze(freeze), .idPc(idPc),
		.idInstr(idInstr), .rsData(rsData), .rtData(rtData), .fwdBrA(fwdBrA),
		.fwdBrB(fwdBrB), .memFwd(memFwd), .wbFwd(wbStage.data), .rsAddr(rsAddr),
		.rtAddr(rtAddr), .isBranch(isBranch), .npcSel(npcSel),
		.branchTarget(branchTarget), .exStage(exStage)
	);

	regFile u_regFile (
		.clk(clk), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr), .wbStage(wbStage),
		.rsData(rsData), .rtData(rtData)
	);

	execAlu u_execAlu (
		.clk(clk), .rstN(rstN), .freeze(freeze), .exStage(exStage), .fwdA(fwdA),
		.fwdB(fwdB), .memFwd(memFwd), .wbFwd(wbStage.data), .memStage(memStage)
	);

	memAccess u_memAccess (
		.clk(clk), .rstN(rstN), .freeze(freeze), .memStage(memStage),
		.dataResp(dataResp), .dataBus(dataBus), .dataBusy(dataBusy), .memFwd(memFwd),
		.wbStage(wbStage)
	);

	hazardUnit u_hazardUnit (
		.rsAddr(rsAddr), .rtAddr(rtAddr), .isBranch(isBranch), .exStage(exStage),
		.memStage(memStage), .wbStage(wbStage), .fetchBusy(fetchBusy),
		.dataBusy(dataBusy), .stall(stall), .freeze(freeze), .fwdA(fwdA), .fwdB(fwdB),
		.fwdBrA(fwdBrA), .fwdBrB(fwdBrB)
	);

	// MEM/WB holds during a freeze, so trace only its first cycle
	always_ff @(posedge clk) begin
		if (!rstN)
			wbFresh <= 1'b0;
		else
			wbFresh <= !freeze;
	end

	assign debugWbPc = wbStage.pc;
	assign debugWbRfWen = {4{wbStage.regWr && wbFresh}};
	assign debugWbRfWnum = wbStage.dest;
	assign debugWbRfWdata = wbStage.data;

endmodule

`default_nettype wire

/* bench/mipsCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;

	localparam logic [31:0] BootPc = 32'hbfc0_0000;
	localparam int ResetCycles = 10;
	localparam int DrainCycles = 20;

	logic clk;
	logic rstN;
	wbSlaveT instrResp;
	wbSlaveT dataResp;
	wbMasterT instrBus;
	wbMasterT dataBus;
	logic [31:0] debugWbPc;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	logic [31:0] patterns [0:255];
	logic [31:0] dataRam [0:63];
	logic [31:0] rngState;
	logic [1:0] instrWait;
	logic [1:0] dataWait;
	bit instrPending;
	bit dataPending;
	bit started;
	int nProg, nTrace, nStore, traceBase, storeBase;
	int traceIdx, storeIdx, checkCount, errorCount, watchdogCycles;
	int testErrs [4];
	string testNames [4] = '{"reset", "writeback trace", "retire count", "stores"};

	mipsCore #(.ResetPc(BootPc)) u_mipsCore (
		.clk(clk), .rstN(rstN), .instrResp(instrResp), .dataResp(dataResp),
		.instrBus(instrBus), .dataBus(dataBus), .debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen), .debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// words past the program read as nop
	function automatic logic [31:0] fetchWord(input logic [31:0] adr);
		logic [31:0] offset;
		offset = (adr - BootPc) >> 2;
		if (adr >= BootPc && offset < 32'(nProg))
			return patterns[3 + offset];
		return 32'h0;
	endfunction

	task automatic checkValue(input int testId, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			testErrs[testId]++;
			$display("[FAIL] %s, %s: expected %h, actual %h", testNames[testId], what,
				expected, actual);
		end
	endtask

	task automatic noteError(input int testId, input string msg);
		errorCount++;
		testErrs[testId]++;
		$display("%s: %s", testNames[testId], msg);
	endtask

	task automatic reportTest(input int testId);
		if (testErrs[testId] == 0)
			$display("test %s: ok", testNames[testId]);
		else
			$display("test %s: %0d errors", testNames[testId], testErrs[testId]);
	endtask

	task automatic serveData();
		checkValue(3, "data select", 32'hf, {28'b0, dataBus.sel});
		if (dataBus.adr[31:8] != 24'h0) begin
			noteError(3, $sformatf("data access outside the RAM at address %h", dataBus.adr));
			dataResp.datR = 32'h0;
		end else if (dataBus.we) begin
			if (storeIdx < nStore) begin
				checkValue(3, $sformatf("store %0d address", storeIdx),
					patterns[storeBase + 2 * storeIdx], dataBus.adr);
				checkValue(3, $sformatf("store %0d data", storeIdx),
					patterns[storeBase + 2 * storeIdx + 1], dataBus.datW);
			end else begin
				noteError(3, $sformatf("unexpected store to address %h", dataBus.adr));
			end
			storeIdx++;
			dataRam[dataBus.adr[7:2]] = dataBus.datW;
		end else begin
			dataResp.datR = dataRam[dataBus.adr[7:2]];
		end
	endtask

	// both slaves answer each request after 0 to 3 wait states
	always @(negedge clk) begin
		instrResp.ack = 1'b0;
		if (instrBus.stb) begin
			if (!instrPending) begin
				instrPending = 1'b1;
				rngState = lcgNext(rngState);
				instrWait = rngState[17:16];
			end
			if (instrWait == 2'd0) begin
				instrResp.ack = 1'b1;
				instrResp.datR = fetchWord(instrBus.adr);
				instrPending = 1'b0;
				checkValue(1, "fetch write enable", 32'h0, {31'b0, instrBus.we});
				checkValue(1, "fetch select", 32'hf, {28'b0, instrBus.sel});
			end else begin
				instrWait = instrWait - 2'd1;
			end
		end
		dataResp.ack = 1'b0;
		if (dataBus.stb) begin
			if (!dataPending) begin
				dataPending = 1'b1;
				rngState = lcgNext(rngState);
				dataWait = rngState[17:16];
			end
			if (dataWait == 2'd0) begin
				dataResp.ack = 1'b1;
				serveData();
				dataPending = 1'b0;
			end else begin
				dataWait = dataWait - 2'd1;
			end
		end
	end

	// retire monitor
	always @(negedge clk) begin
		if (rstN && debugWbRfWen != 4'h0) begin
			if (traceIdx < nTrace) begin
				checkValue(1, $sformatf("entry %0d pc", traceIdx),
					patterns[traceBase + 3 * traceIdx], debugWbPc);
				checkValue(1, $sformatf("entry %0d register", traceIdx),
					patterns[traceBase + 3 * traceIdx + 1], {27'b0, debugWbRfWnum});
				checkValue(1, $sformatf("entry %0d value", traceIdx),
					patterns[traceBase + 3 * traceIdx + 2], debugWbRfWdata);
				checkValue(1, $sformatf("entry %0d write enable", traceIdx),
					32'hf, {28'b0, debugWbRfWen});
			end else begin
				noteError(1, $sformatf("write retired beyond the trace at pc %h", debugWbPc));
			end
			traceIdx++;
		end
	end

	initial begin
		wait (started);
		repeat (watchdogCycles) @(posedge clk);
		$display("watchdog: the run did not finish within %0d cycles", watchdogCycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		instrResp = '0;
		dataResp = '0;
		rngState = 32'd3683;
		$readmemh("bench/mipsPatterns.mem", patterns);
		nProg = int'(patterns[0]);
		nTrace = int'(patterns[1]);
		nStore = int'(patterns[2]);
		traceBase = 3 + nProg;
		storeBase = traceBase + 3 * nTrace;
		// untouched RAM reads back 0xdead0000 plus its address
		for (int i = 0; i < 64; i++)
			dataRam[i] = 32'hdead_0000 + 32'(i * 4);
		watchdogCycles = ResetCycles + 40 * nTrace;
		started = 1'b1;

		repeat (ResetCycles) begin
			@(negedge clk);
			checkValue(0, "instruction cyc in reset", 32'h0, {31'b0, instrBus.cyc});
			checkValue(0, "data cyc in reset", 32'h0, {31'b0, dataBus.cyc});
			checkValue(0, "write enable in reset", 32'h0, {28'b0, debugWbRfWen});
		end
		rstN = 1'b1;
		while (!instrBus.stb)
			@(negedge clk);
		checkValue(0, "first fetch address", BootPc, instrBus.adr);
		checkValue(0, "data cyc at first fetch", 32'h0, {31'b0, dataBus.cyc});
		reportTest(0);

		while (traceIdx < nTrace)
			@(negedge clk);
		reportTest(1);

		// extra retires or stores would show up here
		repeat (DrainCycles) @(negedge clk);
		checkValue(2, "retired writes", 32'(nTrace), 32'(traceIdx));
		reportTest(2);
		checkValue(3, "completed stores", 32'(nStore), 32'(storeIdx));
		reportTest(3);

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/mipsPatterns.mem */
// header: program word count, trace entry count, store count; then program words from 0xbfc00000
// then trace entries as pc, register, value and stores as address, data
00000024 00000017 00000004
// program
24010005 2402fffd 00221821 00222023 3c051234 34a55678
30a6ff0f 00a63826 00a74024 00264825 0041502a 282bffff
00016100 00026f02 24140040 ae850000 ae8d0004 8e8e0000
01c17821 8e900008 120e0004 24110001 16210002 24120002
24130bad 12520002 ae920008 24130bad 0ff00020 24150007
24130bad 24130bad 03e0b021 ae96000c 0bf00022 00000000
// trace: alu and immediates
bfc00000 01 00000005
bfc00004 02 fffffffd
bfc00008 03 00000002
bfc0000c 04 00000008
bfc00010 05 12340000
bfc00014 05 12345678
bfc00018 06 00005608
bfc0001c 07 12340070
bfc00020 08 12340070
bfc00024 09 0000560d
bfc00028 0a 00000001
bfc0002c 0b 00000000
bfc00030 0c 00000050
bfc00034 0d 0000000f
bfc00038 14 00000040
// trace: loads, load-use and branch stalls
bfc00044 0e 12345678
bfc00048 0f 1234567d
bfc0004c 10 dead0048
bfc00054 11 00000001
bfc0005c 12 00000002
// trace: jal link and its use
bfc00070 1f bfc00078
bfc00074 15 00000007
bfc00080 16 bfc00078
// stores
00000040 12345678
00000044 0000000f
00000048 00000002
0000004c bfc00078

/* compile.f */
source/mipsPkg.sv
source/regFile.sv
source/hazardUnit.sv
source/fetchUnit.sv
source/decodeCtrl.sv
source/execAlu.sv
source/memAccess.sv
source/mipsCore.sv
bench/mipsCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mipsCoreTb \
	-f compile.f -o mipsCoreSim
./obj_dir/mipsCoreSim | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"
